// File: src/sat_cfg_pkg.sv
package sat_cfg_pkg;

  // ##########################################################
  // Sizing of the variable space and the clauses
  // ##########################################################
  localparam int VAR_W           = 3;           // Bits per variable index
  localparam int NUM_VARS        = 1 << VAR_W;  // One table bit per variable
  localparam int LITS_PER_CLAUSE = 3;           // 3-SAT

  // ##########################################################
  // Window timing
  // ##########################################################
  // One ring step lasts STEP_CYCLES clocks, and the evaluators settle in that time
  localparam int STEP_CYCLES     = 4;
  localparam int STEP_CNT_W      = 2;           // Holds 0 .. STEP_CYCLES-1

  // Ring size used by the top level unless overridden
  localparam int DEFAULT_SLOTS   = 8;

endpackage

// File: src/sat_types_pkg.sv
package sat_types_pkg;

  // Variable index, 0 .. NUM_VARS-1
  typedef logic [sat_cfg_pkg::VAR_W-1:0] var_idx_t;

  // Literal of a clause
  // True when the variable value differs from neg
  typedef struct packed {
    var_idx_t idx;   // Variable
    logic     neg;   // 1 for the negated form
  } literal_t;

  // Literals not yet resolved by an assignment
  typedef logic [sat_cfg_pkg::LITS_PER_CLAUSE-1:0] lit_mask_t;

  // One clause slot of the ring, 17 bits
  typedef struct packed {
    literal_t [sat_cfg_pkg::LITS_PER_CLAUSE-1:0] lits;  // lits[0] in the low bits
    lit_mask_t                                   mask;  // Bit i follows lits[i]
    logic                                        active;  // Cleared once satisfied
    logic                                        valid;   // Slot holds a clause
  } clause_t;

  // One entry of the assignment table
  typedef struct packed {
    var_idx_t idx;    // Variable being assigned
    logic     value;  // Its boolean value
    logic     valid;  // Entry in use
  } assign_t;

  // One bit per variable
  typedef logic [sat_cfg_pkg::NUM_VARS-1:0] var_bits_t;

endpackage

// File: src/clause_eval.sv
module clause_eval
(
  input  sat_types_pkg::clause_t clause_in,
  input  sat_types_pkg::assign_t assign_in,
  output sat_types_pkg::clause_t clause_out
);

  // ##########################################################
  // Apply one assignment to the open literals of one clause
  // ##########################################################

  logic apply;  // Clause can still change

  // Only a live clause against a live table entry does anything
  assign apply = clause_in.valid & clause_in.active & assign_in.valid;

  always_comb
  begin
    clause_out = clause_in;  // Default is pass through
    if (apply)
    begin
      for (int i = 0; i < sat_cfg_pkg::LITS_PER_CLAUSE; i++)
      begin
        // Literal still open and on the assigned variable
        if (clause_in.mask[i] && (clause_in.lits[i].idx == assign_in.idx))
        begin
          if (assign_in.value != clause_in.lits[i].neg)
          begin
            clause_out.active = 1'b0;   // True literal satisfies the clause
          end
          else
          begin
            clause_out.mask[i] = 1'b0;  // False literal drops out
          end
        end
      end
    end
  end

  // A clause with x and ~x on one variable loses a mask bit
  // and goes inactive in the same pass
  // Downstream logic ignores inactive clauses anyway

endmodule

// File: src/clause_ring.sv
module clause_ring
#(
  parameter int NUM_SLOTS = sat_cfg_pkg::DEFAULT_SLOTS
)
(
  input  logic                   clk,
  input  logic                   total_ckt_reset,
  input  logic                   load,
  input  logic                   shift,
  input  sat_types_pkg::clause_t clauses_in [NUM_SLOTS],
  input  sat_types_pkg::assign_t assigns_in [NUM_SLOTS],
  output sat_types_pkg::clause_t ring       [NUM_SLOTS]
);

  // ##########################################################
  // Storage
  // ##########################################################
  sat_types_pkg::clause_t slot_q   [NUM_SLOTS];  // Clause slots, move on every shift
  sat_types_pkg::assign_t tbl_q    [NUM_SLOTS];  // Assignment per slot, fixed for a run
  sat_types_pkg::clause_t eval_out [NUM_SLOTS];  // Slot content after its assignment
  sat_types_pkg::clause_t slot_d   [NUM_SLOTS];  // Next slot value

  // ##########################################################
  // Per-slot evaluators
  // ##########################################################
  for (genvar k = 0; k < NUM_SLOTS; k++)
  begin : g_eval
    clause_eval i_eval
    (
      .clause_in  (slot_q[k]),
      .assign_in  (tbl_q[k]),
      .clause_out (eval_out[k])
    );
  end

  // ##########################################################
  // Load and shift muxes
  // ##########################################################
  always_comb
  begin
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      if (load)
      begin
        slot_d[k] = clauses_in[k];  // Load wins
      end
      else if (shift)
      begin
        // Slot 0 wraps from the last slot
        slot_d[k] = (k == 0) ? eval_out[NUM_SLOTS-1] : eval_out[k-1];
      end
      else
      begin
        slot_d[k] = slot_q[k];  // Hold
      end
    end
  end

  // Clause slots, emptied on reset
  always_ff @(posedge clk)
  begin
    if (total_ckt_reset)
    begin
      for (int k = 0; k < NUM_SLOTS; k++)
      begin
        slot_q[k] <= '0;  // valid = 0
      end
    end
    else
    begin
      slot_q <= slot_d;
    end
  end

  // Assignment table, latched with the clauses
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      tbl_q <= assigns_in;
    end
  end

  assign ring = slot_q;  // Ring contents straight from the flops

  // ##########################################################
  // Checks
  // ##########################################################
  // Controller must never ask for a shift in a load cycle
  a_no_shift_on_load : assert property (
    @(posedge clk) disable iff (total_ckt_reset)
    load |-> !shift
  );

endmodule

// File: src/window_ctrl.sv
module window_ctrl
#(
  parameter int NUM_SLOTS = sat_cfg_pkg::DEFAULT_SLOTS
)
(
  input  logic clk,
  input  logic total_ckt_reset,
  input  logic load,
  output logic shift,
  output logic done
);

  localparam int SHIFT_W = $clog2(NUM_SLOTS);  // Counts shifts of one turn

  logic [sat_cfg_pkg::STEP_CNT_W-1:0] step_cnt;   // Cycle within a step
  logic [SHIFT_W-1:0]                 shift_cnt;  // Shifts done this turn
  logic                               running;    // Turn in progress
  logic                               step_last;  // Last cycle of a step
  logic                               turn_last;  // Next shift closes the turn

  assign step_last = (step_cnt == sat_cfg_pkg::STEP_CNT_W'(sat_cfg_pkg::STEP_CYCLES - 1));
  assign turn_last = (shift_cnt == SHIFT_W'(NUM_SLOTS - 1));

  // Pulse at the end of each step but not in a load cycle
  assign shift = running & step_last & ~load;

  // ##########################################################
  // Counters and done
  // ##########################################################
  always_ff @(posedge clk)
  begin
    if (total_ckt_reset)
    begin
      step_cnt  <= '0;
      shift_cnt <= '0;
      running   <= 1'b0;
      done      <= 1'b0;
    end
    else if (load)
    begin
      step_cnt  <= '0;    // Restart even mid-run
      shift_cnt <= '0;
      running   <= 1'b1;
      done      <= 1'b0;
    end
    else if (running)
    begin
      step_cnt <= step_last ? '0 : step_cnt + 1'b1;
      if (shift)
      begin
        shift_cnt <= shift_cnt + 1'b1;
        if (turn_last)
        begin
          shift_cnt <= '0;
          running   <= 1'b0;  // Ring freezes
          done      <= 1'b1;  // Held until next load
        end
      end
    end
  end

  // ##########################################################
  // Checks
  // ##########################################################
  a_no_shift_when_done : assert property (
    @(posedge clk) disable iff (total_ckt_reset)
    done |-> !shift
  );

endmodule

// File: src/unit_finder.sv
module unit_finder
#(
  parameter int NUM_SLOTS = sat_cfg_pkg::DEFAULT_SLOTS
)
(
  input  logic                    clk,
  input  logic                    total_ckt_reset,
  input  sat_types_pkg::clause_t  ring     [NUM_SLOTS],
  output logic [NUM_SLOTS-1:0]    unit_hit,
  output sat_types_pkg::literal_t unit_lit [NUM_SLOTS]
);

  logic [NUM_SLOTS-1:0]    hit_d;        // Unit clause in slot
  sat_types_pkg::literal_t lit_d [NUM_SLOTS];  // Its remaining literal

  // ##########################################################
  // Detect exactly one open literal per live clause
  // ##########################################################
  always_comb
  begin
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      hit_d[k] = ring[k].valid & ring[k].active;
      lit_d[k] = ring[k].lits[0];
      case (ring[k].mask)
        3'b001 : lit_d[k] = ring[k].lits[0];
        3'b010 : lit_d[k] = ring[k].lits[1];
        3'b100 : lit_d[k] = ring[k].lits[2];
        default: hit_d[k] = 1'b0;  // None or several open
      endcase
    end
  end

  // ##########################################################
  // Register stage
  // ##########################################################
  always_ff @(posedge clk)
  begin
    if (total_ckt_reset)
    begin
      unit_hit <= '0;
    end
    else
    begin
      unit_hit <= hit_d;
    end
  end

  // Remaining literal per slot
  always_ff @(posedge clk)
  begin
    unit_lit <= lit_d;
  end

endmodule

// File: src/unit_marker.sv
module unit_marker
#(
  parameter int NUM_SLOTS = sat_cfg_pkg::DEFAULT_SLOTS
)
(
  input  logic                     clk,
  input  logic                     total_ckt_reset,
  input  logic [NUM_SLOTS-1:0]     unit_hit,
  input  sat_types_pkg::literal_t  unit_lit [NUM_SLOTS],
  output sat_types_pkg::var_bits_t unit_marks,
  output sat_types_pkg::var_bits_t unit_values,
  output logic                     unit_found
);

  sat_types_pkg::var_bits_t marks_d;   // Variable has a unit clause
  sat_types_pkg::var_bits_t values_d;  // Value that satisfies it

  // ##########################################################
  // Priority merge, lowest slot wins per variable
  // ##########################################################
  always_comb
  begin
    marks_d  = '0;
    values_d = '0;
    for (int v = 0; v < sat_cfg_pkg::NUM_VARS; v++)
    begin
      // Walk downwards so the lowest hit slot is written last
      for (int k = NUM_SLOTS - 1; k >= 0; k--)
      begin
        if (unit_hit[k] && (unit_lit[k].idx == sat_types_pkg::var_idx_t'(v)))
        begin
          marks_d[v]  = 1'b1;
          values_d[v] = ~unit_lit[k].neg;  // Makes the literal true
        end
      end
    end
  end

  // ##########################################################
  // Output registers
  // ##########################################################
  always_ff @(posedge clk)
  begin
    if (total_ckt_reset)
    begin
      unit_marks  <= '0;
      unit_values <= '0;
      unit_found  <= 1'b0;
    end
    else
    begin
      unit_marks  <= marks_d;
      unit_values <= values_d;
      unit_found  <= |marks_d;  // Any unit this cycle
    end
  end

  // Value bit without its mark would hand a stale value to the solver
  a_value_needs_mark : assert property (
    @(posedge clk) disable iff (total_ckt_reset)
    (unit_values & ~unit_marks) == '0
  );

endmodule

// File: src/sat_window_top.sv
module sat_window_top
#(
  parameter int NUM_SLOTS = sat_cfg_pkg::DEFAULT_SLOTS
)
(
  input  logic                     clk,
  input  logic                     total_ckt_reset,
  input  logic                     load,          // One-cycle strobe
  input  sat_types_pkg::clause_t   clauses_in  [NUM_SLOTS],
  input  sat_types_pkg::assign_t   assigns_in  [NUM_SLOTS],
  output sat_types_pkg::clause_t   clauses_out [NUM_SLOTS],
  output logic                     done,
  output sat_types_pkg::var_bits_t unit_marks,
  output sat_types_pkg::var_bits_t unit_values,
  output logic                     unit_found
);

  // ##########################################################
  // Internal nets
  // ##########################################################
  logic                    shift;     // Ring step pulse
  logic [NUM_SLOTS-1:0]    unit_hit;  // Finder to marker
  sat_types_pkg::literal_t unit_lit [NUM_SLOTS];

  // Step and turn control
  window_ctrl #(
    .NUM_SLOTS (NUM_SLOTS)
  ) i_ctrl (
    .clk             (clk),
    .total_ckt_reset (total_ckt_reset),
    .load            (load),
    .shift           (shift),
    .done            (done)
  );

  // Clause slots and evaluators, contents go straight out
  clause_ring #(
    .NUM_SLOTS (NUM_SLOTS)
  ) i_ring (
    .clk             (clk),
    .total_ckt_reset (total_ckt_reset),
    .load            (load),
    .shift           (shift),
    .clauses_in      (clauses_in),
    .assigns_in      (assigns_in),
    .ring            (clauses_out)
  );

  // ##########################################################
  // Unit pipeline, two stages
  // ##########################################################
  unit_finder #(
    .NUM_SLOTS (NUM_SLOTS)
  ) i_finder (
    .clk             (clk),
    .total_ckt_reset (total_ckt_reset),
    .ring            (clauses_out),
    .unit_hit        (unit_hit),
    .unit_lit        (unit_lit)
  );

  unit_marker #(
    .NUM_SLOTS (NUM_SLOTS)
  ) i_marker (
    .clk             (clk),
    .total_ckt_reset (total_ckt_reset),
    .unit_hit        (unit_hit),
    .unit_lit        (unit_lit),
    .unit_marks      (unit_marks),
    .unit_values     (unit_values),
    .unit_found      (unit_found)
  );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen
(
  output logic clk,
  output logic total_ckt_reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time CLK_PERIOD   = 20ns;
  localparam int  RESET_CYCLES = 4;  // Edges seen with reset high

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    total_ckt_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2ns total_ckt_reset = 1'b0;  // Same drive offset as the stimulus
  end

endmodule

// File: testbench/sat_window_tb.sv
module sat_window_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_SLOTS      = sat_cfg_pkg::DEFAULT_SLOTS;
  localparam int TURN_CYCLES    = sat_cfg_pkg::STEP_CYCLES * NUM_SLOTS;  // Load to done
  localparam int NUM_RUNS       = 14;
  localparam int RESTART_RUN    = 6;   // Run that gets a second load midway
  localparam int HOLD_CYCLES    = 4;   // Frozen-output check after done
  localparam int TIMEOUT_CYCLES = 20 * (TURN_CYCLES + 20);

  logic                     clk;
  logic                     total_ckt_reset;
  logic                     load;
  sat_types_pkg::clause_t   clauses_in  [NUM_SLOTS];
  sat_types_pkg::assign_t   assigns_in  [NUM_SLOTS];
  sat_types_pkg::clause_t   clauses_out [NUM_SLOTS];
  logic                     done;
  sat_types_pkg::var_bits_t unit_marks;
  sat_types_pkg::var_bits_t unit_values;
  logic                     unit_found;

  integer seed;
  int     clause_errs = 0;
  int     bits_errs   = 0;
  int     flag_errs   = 0;
  int     cycle_cnt   = 0;

  sat_types_pkg::clause_t   stim_clauses [NUM_SLOTS];  // Data of the next load
  sat_types_pkg::assign_t   stim_assigns [NUM_SLOTS];
  sat_types_pkg::clause_t   exp_clauses  [NUM_SLOTS];  // Model results
  sat_types_pkg::var_bits_t exp_marks;
  sat_types_pkg::var_bits_t exp_values;
  logic                     exp_found;

  tb_clock_gen i_clk_gen
  (
    .clk             (clk),
    .total_ckt_reset (total_ckt_reset)
  );

  sat_window_top #(
    .NUM_SLOTS (NUM_SLOTS)
  ) i_dut (
    .clk             (clk),
    .total_ckt_reset (total_ckt_reset),
    .load            (load),
    .clauses_in      (clauses_in),
    .assigns_in      (assigns_in),
    .clauses_out     (clauses_out),
    .done            (done),
    .unit_marks      (unit_marks),
    .unit_values     (unit_values),
    .unit_found      (unit_found)
  );

  // Hang guard
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Run did not finish within %0d cycles and was stopped", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  // ##########################################################
  // Compare tasks
  // ##########################################################
  task automatic check_clause(input string name, input sat_types_pkg::clause_t expected,
                              input sat_types_pkg::clause_t actual);
    if (actual !== expected)
    begin
      $display("FAILED at %0t %s expected %h actual %h", $time, name, expected, actual);
      clause_errs++;
    end
  endtask

  task automatic check_bits(input string name, input sat_types_pkg::var_bits_t expected,
                            input sat_types_pkg::var_bits_t actual);
    if (actual !== expected)
    begin
      $display("FAILED at %0t %s expected %b actual %b", $time, name, expected, actual);
      bits_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("FAILED at %0t %s expected %b actual %b", $time, name, expected, actual);
      flag_errs++;
    end
  endtask

  // Edge plus the drive and sample offset
  task automatic tick();
    @(posedge clk);
    #2ns;
  endtask

  // ##########################################################
  // Stimulus and reference model
  // ##########################################################
  task automatic make_stimulus(input bit force_unit);
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      for (int i = 0; i < sat_cfg_pkg::LITS_PER_CLAUSE; i++)
      begin
        stim_clauses[k].lits[i].idx = sat_types_pkg::var_idx_t'($random(seed));
        stim_clauses[k].lits[i].neg = 1'($random(seed));
      end
      stim_clauses[k].mask   = '1;  // All literals open
      stim_clauses[k].active = 1'b1;
      stim_clauses[k].valid  = 1'($random(seed));
      stim_assigns[k].idx    = sat_types_pkg::var_idx_t'($random(seed));
      stim_assigns[k].value  = 1'($random(seed));
      stim_assigns[k].valid  = (($random(seed) & 3) != 0);  // About 3 in 4
    end
    if (force_unit)
    begin
      // Slot 0 uses vars 0..2 with vars 0 and 1 made false
      // Var 2 stays open so slot 0 ends as a unit
      stim_clauses[0].valid = 1'b1;
      for (int i = 0; i < sat_cfg_pkg::LITS_PER_CLAUSE; i++)
      begin
        stim_clauses[0].lits[i].idx = sat_types_pkg::var_idx_t'(i);
      end
      // Slot 1 repeats it with var 2 inverted so slot 0 has to win the mark
      stim_clauses[1]             = stim_clauses[0];
      stim_clauses[1].lits[2].neg = ~stim_clauses[0].lits[2].neg;
      for (int k = 0; k < NUM_SLOTS; k++)
      begin
        if (k < 2)
        begin
          stim_assigns[k].idx   = sat_types_pkg::var_idx_t'(k);
          stim_assigns[k].value = stim_clauses[0].lits[k].neg;
          stim_assigns[k].valid = 1'b1;
        end
        else if (stim_assigns[k].idx <= 2)
        begin
          // Moved onto vars 3..5
          stim_assigns[k].idx = stim_assigns[k].idx + sat_types_pkg::var_idx_t'(3);
        end
      end
    end
  endtask

  // Clause meets one table entry
  function automatic sat_types_pkg::clause_t apply_assign(input sat_types_pkg::clause_t c,
                                                         input sat_types_pkg::assign_t a);
    sat_types_pkg::clause_t r;
    r = c;
    if (c.valid && c.active && a.valid)
    begin
      for (int i = 0; i < sat_cfg_pkg::LITS_PER_CLAUSE; i++)
      begin
        if (c.mask[i] && (c.lits[i].idx == a.idx))
        begin
          if (a.value ^ c.lits[i].neg)
          begin
            r.active = 1'b0;   // Satisfied
          end
          else
          begin
            r.mask[i] = 1'b0;  // Literal gone
          end
        end
      end
    end
    return r;
  endfunction

  task automatic build_model();
    sat_types_pkg::clause_t  c;
    sat_types_pkg::literal_t lit;
    exp_marks  = '0;
    exp_values = '0;
    for (int h = 0; h < NUM_SLOTS; h++)
    begin
      c = stim_clauses[h];
      for (int j = 0; j < NUM_SLOTS; j++)
      begin
        c = apply_assign(c, stim_assigns[(h + j) % NUM_SLOTS]);  // Home slot first
      end
      exp_clauses[h] = c;
    end
    // Lowest unit slot claims each variable
    for (int h = 0; h < NUM_SLOTS; h++)
    begin
      c   = exp_clauses[h];
      lit = c.lits[0];
      for (int i = 0; i < sat_cfg_pkg::LITS_PER_CLAUSE; i++)
      begin
        if (c.mask[i])
        begin
          lit = c.lits[i];
        end
      end
      if (c.valid && c.active && ($countones(c.mask) == 1) && !exp_marks[lit.idx])
      begin
        exp_marks[lit.idx]  = 1'b1;
        exp_values[lit.idx] = ~lit.neg;
      end
    end
    exp_found = |exp_marks;
  endtask

  // ##########################################################
  // Sequences
  // ##########################################################
  task automatic check_idle();
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      check_bit($sformatf("clauses_out[%0d].valid", k), 1'b0, clauses_out[k].valid);
    end
    check_bit("done", 1'b0, done);
    check_bits("unit_marks", '0, unit_marks);
    check_bits("unit_values", '0, unit_values);
    check_bit("unit_found", 1'b0, unit_found);
  endtask

  task automatic issue_load();
    clauses_in = stim_clauses;
    assigns_in = stim_assigns;
    load       = 1'b1;
    tick();                      // Load edge
    load       = 1'b0;
  endtask

  task automatic await_done();
    for (int e = 1; e < TURN_CYCLES; e++)
    begin
      tick();
      check_bit("done", 1'b0, done);
    end
    tick();
    check_bit("done", 1'b1, done);
  endtask

  task automatic check_ring();
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      check_clause($sformatf("clauses_out[%0d]", k), exp_clauses[k], clauses_out[k]);
    end
  endtask

  task automatic check_marks();
    check_bits("unit_marks", exp_marks, unit_marks);
    check_bits("unit_values", exp_values, unit_values);
    check_bit("unit_found", exp_found, unit_found);
  endtask

  // Ring checked at the done edge and marks two edges later
  // Then everything must hold while frozen
  task automatic check_results();
    check_ring();
    repeat (2) tick();
    check_marks();
    for (int n = 0; n < HOLD_CYCLES; n++)
    begin
      tick();
      check_bit("done", 1'b1, done);
      check_ring();
      check_marks();
    end
  endtask

  // ##########################################################
  // Main sequence
  // ##########################################################
  initial
  begin
    seed = 32'h748a;
    load = 1'b0;
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      clauses_in[k] = '0;
      assigns_in[k] = '0;
    end
    tick();                          // Inside reset
    check_idle();
    @(negedge total_ckt_reset);
    check_idle();
    tick();                          // First edge out of reset
    check_idle();
    for (int r = 0; r < NUM_RUNS; r++)
    begin
      make_stimulus(r % 3 == 0);
      if (r == RESTART_RUN)
      begin
        issue_load();                // Data abandoned halfway
        for (int e = 0; e < TURN_CYCLES / 2; e++)
        begin
          tick();
          check_bit("done", 1'b0, done);
        end
        make_stimulus(1'b0);
      end
      build_model();
      issue_load();
      await_done();
      check_results();
    end
    $display("Errors: clause %0d, var bits %0d, flags %0d", clause_errs, bits_errs,
             flag_errs);
    if ((clause_errs + bits_errs + flag_errs) == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: list.f
src/sat_cfg_pkg.sv
src/sat_types_pkg.sv
src/clause_eval.sv
src/clause_ring.sv
src/window_ctrl.sv
src/unit_finder.sv
src/unit_marker.sv
src/sat_window_top.sv
testbench/tb_clock_gen.sv
testbench/sat_window_tb.sv
